// ==== Bender.yml ====
package:
  name: uart_cmd_link

sources:
  # package first, then the design
  - files:
      - common/uart_pkg.sv
      - uart_tx/uart_cmd_serializer.sv
      - uart_tx/uart_frame_tx.sv
      - uart_rx/uart_frame_rx.sv
      - hw/uart_cmd_top.sv

  # testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_uart_cmd.sv

// ==== common/uart_pkg.sv ====
package uart_pkg;

  // line timing
  localparam int unsigned clk_hz     = 50_000_000;
  localparam int unsigned baud_rate  = 115_200;
  localparam int unsigned bit_cycles = clk_hz / baud_rate;

  // frame layout: start, 8 data, odd parity, stop
  localparam int unsigned data_width = 8;
  localparam int unsigned cmd_width  = 2 * data_width;
  localparam int unsigned frame_bits = 11;

  localparam int unsigned cycle_cnt_width = $clog2(bit_cycles);
  localparam int unsigned bit_idx_width   = $clog2(frame_bits);

  typedef logic [cycle_cnt_width-1:0] cycle_cnt_t;
  typedef logic [bit_idx_width-1:0]   bit_idx_t;

  // last cycle of a full bit period
  localparam cycle_cnt_t bit_last      = cycle_cnt_t'(bit_cycles - 1);
  // last cycle before the middle of the start bit
  localparam cycle_cnt_t half_bit_last = cycle_cnt_t'(bit_cycles / 2 - 1);

  // tx counts the start bit as index 0, so the stop bit is index 10
  localparam bit_idx_t frame_last = bit_idx_t'(frame_bits - 1);
  // rx counts from the first data bit, so the stop bit is index 9
  localparam bit_idx_t stop_idx   = bit_idx_t'(frame_bits - 2);

  // command word, sent high byte first
  typedef struct packed {
    logic [data_width-1:0] hi;
    logic [data_width-1:0] lo;
  } cmd_t;

  // one received frame
  typedef struct packed {
    logic                  parity_err;
    logic [data_width-1:0] data;
  } rx_byte_t;

endpackage

// ==== files.f ====
common/uart_pkg.sv
uart_tx/uart_cmd_serializer.sv
uart_tx/uart_frame_tx.sv
uart_rx/uart_frame_rx.sv
hw/uart_cmd_top.sv
test/tb_clock_gen.sv
test/tb_uart_cmd.sv

// ==== hw/uart_cmd_top.sv ====
module uart_cmd_top #(
  parameter bit parity_check = 1'b1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::cmd_t     cmd_in,
  input  logic               cmd_vld,
  input  logic               rx,
  output logic               tx,
  output logic               cmd_rdy,
  output logic               read_rdy,
  output uart_pkg::rx_byte_t read_data
);

  logic [uart_pkg::data_width-1:0] tx_byte;
  logic                            tx_send;
  logic                            tx_busy;
  logic                            tx_done;

  // transmit path
  uart_cmd_serializer i_serializer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .byte_out (tx_byte),
    .send     (tx_send),
    .busy     (tx_busy),
    .done     (tx_done)
  );

  uart_frame_tx i_frame_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .byte_in (tx_byte),
    .send    (tx_send),
    .busy    (tx_busy),
    .done    (tx_done),
    .tx      (tx)
  );

  // receiver runs on its own
  uart_frame_rx #(
    .parity_check (parity_check)
  ) i_frame_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned reset_cycles = 8;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // released just after an edge, like the rest of the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== test/tb_uart_cmd.sv ====
module tb_uart_cmd;

  timeunit 1ns;
  timeprecision 1ps;

  // full sequence runs close to 67k cycles
  localparam int unsigned max_cycles    = 200_000;
  localparam int unsigned n_random      = 4;
  // acceptance edge to the edge that raises cmd_rdy
  localparam int unsigned ready_latency = 2 * uart_pkg::frame_bits * uart_pkg::bit_cycles + 2;

  logic                            clk;
  logic                            rst_n;
  uart_pkg::cmd_t                  cmd_in;
  logic                            cmd_vld;
  logic                            rx;
  logic                            tx;
  logic                            cmd_rdy;
  logic                            read_rdy;
  uart_pkg::rx_byte_t              read_data;

  logic                            use_loopback;
  logic                            drv_rx;
  logic                            cmd_seen;
  string                           test_name;

  uart_pkg::rx_byte_t              exp_q[$];
  logic [uart_pkg::data_width-1:0] tx_q[$];

  int unsigned                     cycle_cnt = 0;
  int unsigned                     n_sent = 0;
  int unsigned                     n_accepted = 0;
  int unsigned                     n_reads = 0;
  int unsigned                     n_expected_reads = 0;
  int unsigned                     reset_errs = 0;
  int unsigned                     hs_errs = 0;
  int unsigned                     data_errs = 0;
  int unsigned                     frame_errs = 0;
  int unsigned                     end_errs = 0;

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  // rx from our own tx or from the bit driver
  assign rx = use_loopback ? tx : drv_rx;

  uart_cmd_top #(
    .parity_check (1'b1)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  // parity bit that leaves an odd count of ones
  function automatic logic odd_parity_bit(input logic [uart_pkg::data_width-1:0] data);
    int unsigned ones;
    ones = 0;
    for (int i = 0; i < uart_pkg::data_width; i++) begin
      ones += data[i];
    end
    return (ones % 2 == 0) ? 1'b1 : 1'b0;
  endfunction

  // start bit in bit 0 followed by data LSB first, parity and stop
  function automatic logic [uart_pkg::frame_bits-1:0] build_frame(
    input logic [uart_pkg::data_width-1:0] data
  );
    return {1'b1, odd_parity_bit(data), data, 1'b0};
  endfunction

  function automatic uart_pkg::rx_byte_t rx_word(
    input logic                            err,
    input logic [uart_pkg::data_width-1:0] data
  );
    uart_pkg::rx_byte_t w;
    w.parity_err = err;
    w.data       = data;
    return w;
  endfunction

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_cmd(input uart_pkg::cmd_t word, input logic hold_vld);
    cmd_in   = word;
    cmd_vld  = 1'b1;
    cmd_seen = 1'b1;
    n_sent++;
    @(negedge clk);
    while (!cmd_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    tx_q.push_back(word.hi);
    tx_q.push_back(word.lo);
    if (use_loopback) begin
      exp_q.push_back(rx_word(1'b0, word.hi));
      exp_q.push_back(rx_word(1'b0, word.lo));
      n_expected_reads += 2;
    end
    if (!hold_vld) begin
      cmd_vld = 1'b0;
    end
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (exp_q.size() != 0 || !cmd_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic drive_bit(input logic value);
    drv_rx = value;
    wait_cycles(uart_pkg::bit_cycles);
  endtask

  task automatic drive_frame(
    input logic [uart_pkg::data_width-1:0] data,
    input logic                            parity_bit
  );
    drive_bit(1'b0);
    for (int i = 0; i < uart_pkg::data_width; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(parity_bit);
    drive_bit(1'b1);
  endtask

  a_reset_state : assert property (
    @(posedge clk) disable iff (!rst_n)
    !cmd_seen |-> (tx && cmd_rdy && !read_rdy)
  ) else begin
    reset_errs++;
    $display("FAILED reset_state: expected %b actual %b", 3'b110,
             $sampled({tx, cmd_rdy, read_rdy}));
  end

  a_rdy_falls : assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy
  ) else begin
    hs_errs++;
    $display("FAILED %s cmd_rdy after accept: expected %b actual %b", test_name, 1'b0,
             $sampled(cmd_rdy));
  end

  // a start bit only ever belongs to an accepted command
  a_start_in_transfer : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(tx) |-> !cmd_rdy
  ) else begin
    hs_errs++;
    $display("FAILED %s cmd_rdy at start bit: expected %b actual %b", test_name, 1'b0,
             $sampled(cmd_rdy));
  end

  initial begin : accept_monitor
    int unsigned low_cycles;
    forever begin
      @(negedge clk);
      while (rst_n && cmd_vld && cmd_rdy) begin
        n_accepted++;
        low_cycles = 0;
        @(negedge clk);
        while (!cmd_rdy) begin
          low_cycles++;
          // start bit one cycle after acceptance
          if (low_cycles == 2) begin
            assert (tx == 1'b0) else begin
              hs_errs++;
              $display("FAILED %s start delay: expected %b actual %b", test_name, 1'b0, tx);
            end
          end
          @(negedge clk);
        end
        assert (low_cycles == ready_latency) else begin
          hs_errs++;
          $display("FAILED %s cmd_rdy latency: expected %0d actual %0d", test_name,
                   ready_latency, low_cycles);
        end
      end
    end
  end

  initial begin : read_monitor
    uart_pkg::rx_byte_t exp;
    forever begin
      @(negedge clk);
      if (rst_n && read_rdy) begin
        n_reads++;
        if (exp_q.size() == 0) begin
          data_errs++;
          $display("%s: read_rdy pulsed with no byte pending, data %h", test_name, read_data);
        end else begin
          exp = exp_q.pop_front();
          assert (read_data == exp) else begin
            data_errs++;
            $display("FAILED %s read_data: expected %h actual %h", test_name, exp, read_data);
          end
        end
      end
    end
  end

  // samples tx in the middle of every bit time
  initial begin : frame_monitor
    logic [uart_pkg::frame_bits-1:0] exp_frame;
    logic [uart_pkg::data_width-1:0] exp_byte;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge tx);
      @(negedge clk);
      if (tx_q.size() == 0) begin
        frame_errs++;
        $display("%s: start bit on tx with no byte waiting to be sent", test_name);
      end else begin
        exp_byte  = tx_q.pop_front();
        exp_frame = build_frame(exp_byte);
        repeat (uart_pkg::bit_cycles / 2) @(negedge clk);
        for (int b = 0; b < uart_pkg::frame_bits; b++) begin
          if (b != 0) begin
            repeat (uart_pkg::bit_cycles) @(negedge clk);
          end
          assert (tx == exp_frame[b]) else begin
            frame_errs++;
            $display("FAILED %s frame bit %0d of byte %h: expected %b actual %b", test_name,
                     b, exp_byte, exp_frame[b], tx);
          end
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: sequence still running after %0d cycles", max_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    uart_pkg::cmd_t                  word;
    uart_pkg::cmd_t                  held;
    logic [uart_pkg::data_width-1:0] bad_byte;
    logic [uart_pkg::data_width-1:0] good_byte;
    int unsigned                     total;
    void'($urandom(32'hfb2d_2391));
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    drv_rx       = 1'b1;
    use_loopback = 1'b0;
    cmd_seen     = 1'b0;
    test_name    = "reset_state";
    @(posedge rst_n);
    use_loopback = 1'b1;
    wait_cycles(20);

    test_name = "loopback";
    for (int i = 0; i < n_random; i++) begin
      word.hi = 8'($urandom());
      word.lo = 8'($urandom());
      send_cmd(word, 1'b0);
      wait_drained();
    end

    // second word waits behind the first with cmd_vld held high
    test_name = "back_pressure";
    word.hi = 8'($urandom());
    word.lo = 8'($urandom());
    held.hi = 8'($urandom());
    held.lo = 8'($urandom());
    send_cmd(word, 1'b1);
    send_cmd(held, 1'b0);
    wait_drained();

    test_name    = "parity";
    use_loopback = 1'b0;
    wait_cycles(4);
    bad_byte = 8'($urandom());
    exp_q.push_back(rx_word(1'b1, bad_byte));
    n_expected_reads++;
    drive_frame(bad_byte, !odd_parity_bit(bad_byte));
    drive_bit(1'b1);
    drive_bit(1'b1);
    good_byte = 8'($urandom());
    exp_q.push_back(rx_word(1'b0, good_byte));
    n_expected_reads++;
    drive_frame(good_byte, odd_parity_bit(good_byte));
    wait_drained();

    test_name = "end_of_run";
    assert (n_accepted == n_sent) else begin
      end_errs++;
      $display("FAILED %s accepted commands: expected %0d actual %0d", test_name, n_sent,
               n_accepted);
    end
    assert (n_reads == n_expected_reads) else begin
      end_errs++;
      $display("FAILED %s read_rdy pulses: expected %0d actual %0d", test_name,
               n_expected_reads, n_reads);
    end
    assert (tx_q.size() == 0) else begin
      end_errs++;
      $display("%0d sent bytes never appeared as frames on tx", tx_q.size());
    end

    total = reset_errs + hs_errs + data_errs + frame_errs + end_errs;
    $display("errors: reset %0d, handshake %0d, data %0d, frame %0d, end %0d, total %0d",
             reset_errs, hs_errs, data_errs, frame_errs, end_errs, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== uart_rx/uart_frame_rx.sv ====
module uart_frame_rx #(
  parameter bit parity_check = 1'b1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  output logic               read_rdy,
  output uart_pkg::rx_byte_t read_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_frame
  } state_t;

  state_t                          state;
  logic                            rx_meta;
  logic                            rx_sync;
  logic                            rx_prev;
  logic                            fall;
  uart_pkg::cycle_cnt_t            cyc_cnt;
  uart_pkg::bit_idx_t              bit_idx;
  // data bits then parity, filled from the top
  logic [uart_pkg::data_width:0]   shreg;
  logic                            sample;
  logic                            stop_sample;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall        = rx_prev && !rx_sync;
  assign sample      = (state == st_frame) && (cyc_cnt == uart_pkg::bit_last);
  assign stop_sample = sample && (bit_idx == uart_pkg::stop_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cyc_cnt  <= '0;
      bit_idx  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        st_idle: begin
          if (fall) begin
            state   <= st_start;
            cyc_cnt <= '0;
          end
        end
        st_start: begin
          if (cyc_cnt == uart_pkg::half_bit_last) begin
            cyc_cnt <= '0;
            bit_idx <= '0;
            // a high line at mid start was a glitch
            state   <= rx_sync ? st_idle : st_frame;
          end else begin
            cyc_cnt <= cyc_cnt + uart_pkg::cycle_cnt_t'(1);
          end
        end
        st_frame: begin
          if (sample) begin
            cyc_cnt <= '0;
            if (stop_sample) begin
              read_rdy <= 1'b1;
              state    <= st_idle;
            end else begin
              bit_idx <= bit_idx + uart_pkg::bit_idx_t'(1);
            end
          end else begin
            cyc_cnt <= cyc_cnt + uart_pkg::cycle_cnt_t'(1);
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample && !stop_sample) begin
      shreg <= {rx_sync, shreg[uart_pkg::data_width:1]};
    end
  end

  // even count over data plus parity means a bad frame
  always_ff @(posedge clk) begin
    if (stop_sample) begin
      read_data.data       <= shreg[uart_pkg::data_width-1:0];
      read_data.parity_err <= parity_check && (~^shreg);
    end
  end

  a_read_rdy_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

// ==== uart_tx/uart_cmd_serializer.sv ====
module uart_cmd_serializer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  uart_pkg::cmd_t                  cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic [uart_pkg::data_width-1:0] byte_out,
  output logic                            send,
  input  logic                            busy,
  input  logic                            done
);

  typedef enum logic [1:0] {
    st_idle,
    st_high,
    st_low
  } state_t;

  state_t                          state;
  logic [uart_pkg::cmd_width-1:0]  cmd_q;
  logic                            send_q;
  logic                            accept;

  assign accept = cmd_vld && cmd_rdy;

  // sequencer and handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      cmd_rdy <= 1'b1;
      send_q  <= 1'b0;
    end else begin
      send_q <= accept;
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_high;
            cmd_rdy <= 1'b0;
          end else if (!cmd_rdy) begin
            // one cycle after the low frame's stop bit
            cmd_rdy <= 1'b1;
          end
        end
        st_high: begin
          if (done) begin
            state <= st_low;
          end
        end
        st_low: begin
          if (done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // held word, only meaningful while a transfer runs
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // low byte is issued in the done cycle so the frames run back to back
  assign send = send_q || (state == st_high && done);

  assign byte_out = send_q ? cmd_q[uart_pkg::cmd_width-1 -: uart_pkg::data_width]
                           : cmd_q[uart_pkg::data_width-1:0];

  a_no_send_while_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(send && busy)
  );

endmodule

// ==== uart_tx/uart_frame_tx.sv ====
module uart_frame_tx (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::data_width-1:0] byte_in,
  input  logic                            send,
  output logic                            busy,
  output logic                            done,
  output logic                            tx
);

  logic                                active;
  // data, parity and stop still to go out
  logic [uart_pkg::frame_bits-2:0]     shreg;
  uart_pkg::cycle_cnt_t                cyc_cnt;
  uart_pkg::bit_idx_t                  bit_idx;
  logic                                bit_end;
  logic                                parity;

  // odd parity over data plus parity bit
  assign parity = ~^byte_in;

  assign bit_end = active && (cyc_cnt == uart_pkg::bit_last);
  assign done    = bit_end && (bit_idx == uart_pkg::frame_last);
  // free in the last stop cycle so a new frame can follow directly
  assign busy    = active && !done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      cyc_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else if (send) begin
      active  <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
      // start bit
      tx      <= 1'b0;
    end else if (active) begin
      if (bit_end) begin
        cyc_cnt <= '0;
        tx      <= shreg[0];
        if (done) begin
          active <= 1'b0;
        end else begin
          bit_idx <= bit_idx + uart_pkg::bit_idx_t'(1);
        end
      end else begin
        cyc_cnt <= cyc_cnt + uart_pkg::cycle_cnt_t'(1);
      end
    end
  end

  // shifts right and refills with ones so the line ends idle high
  always_ff @(posedge clk) begin
    if (send) begin
      shreg <= {1'b1, parity, byte_in};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[uart_pkg::frame_bits-2:1]};
    end
  end

  a_idle_high : assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

  a_done_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !done
  );

endmodule
